/* design/bus_controller.sv */
/* wishbone bus controller
   turns a classic cycle into one strobe cycle and a fixed ack two clocks later */
`timescale 1ns/1ps

module bus_controller (
	input  logic                clk,
	input  logic                reset,
	input  logic                cyc,
	input  logic                stb,
	input  logic                we,
	input  glue_pkg::byte_sel_t sel,
	input  glue_pkg::cpu_addr_t adr,
	input  glue_pkg::word_t     dat_w,
	output glue_pkg::word_t     dat_r,
	output logic                ack,
	cpu_bus_if.controller       bus,
	input  glue_pkg::word_t     ram_data,
	input  glue_pkg::word_t     rom_data,
	input  glue_pkg::word_t     periph_data
);
	import glue_pkg::*;

	bus_state_t state;

	// master holds address and data until ack
	assign bus.adr   = adr;
	assign bus.dat_w = dat_w;

	// ----------------------------------------
	// access state machine
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= BUS_IDLE;
			bus.rd  <= 1'b0;
			bus.hwr <= 1'b0;
			bus.lwr <= 1'b0;
			ack     <= 1'b0;
		end else begin
			// strobes and ack are single cycle pulses
			bus.rd  <= 1'b0;
			bus.hwr <= 1'b0;
			bus.lwr <= 1'b0;
			ack     <= 1'b0;
			case (state)
				BUS_IDLE: begin
					if (cyc && stb) begin
						state   <= BUS_ACCESS;
						bus.rd  <= ~we;
						bus.hwr <= we & sel[1];  // upper lane
						bus.lwr <= we & sel[0];  // lower lane
					end
				end
				BUS_ACCESS: begin
					state <= BUS_ACK;
					ack   <= 1'b1;  // target data lands with ack
				end
				BUS_ACK: begin
					state <= BUS_IDLE;  // stb not looked at here
				end
				default: begin
					state <= BUS_IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------
	// read data
	// each target holds its registered word only in the ack cycle
	// and zero otherwise, so a plain or is enough
	assign dat_r = ram_data | rom_data | periph_data;

endmodule

/* design/chip_ram.sv */
/* chip ram
   single port 16 bit memory with byte lane writes and registered read */
`timescale 1ns/1ps

module chip_ram (
	input  logic              clk,
	cpu_bus_if.target         bus,
	input  glue_pkg::region_t region,
	output glue_pkg::word_t   data
);
	import glue_pkg::*;

	localparam int AW = $clog2(CHIP_WORDS);

	word_t          mem [CHIP_WORDS];
	logic [AW-1:0]  idx;  // aliases across the whole chip region

	assign idx = bus.adr[AW-1:0];

	always_ff @(posedge clk) begin
		if (region == REGION_CHIP) begin
			if (bus.hwr)
				mem[idx][15:8] <= bus.dat_w[15:8];
			if (bus.lwr)
				mem[idx][7:0] <= bus.dat_w[7:0];
		end
		// read word shows for one cycle, zero otherwise
		data <= (bus.rd && region == REGION_CHIP) ? mem[idx] : '0;
	end

endmodule

/* design/cpu_bus_if.sv */
/* cpu bus interface
   decoded access from the bus controller out to the targets */
`timescale 1ns/1ps

interface cpu_bus_if;
	import glue_pkg::*;

	cpu_addr_t adr;    // word address, held by the master
	word_t     dat_w;  // write data
	logic      rd;     // one cycle read strobe
	logic      hwr;    // upper byte write strobe
	logic      lwr;    // lower byte write strobe

	// bus controller side
	modport controller (
		output adr, dat_w, rd, hwr, lwr
	);

	// memories, peripherals and the address decoder
	modport target (
		input adr, dat_w, rd, hwr, lwr
	);

endinterface

/* design/glue_pkg.sv */
/* glue package
   shared widths, bus types, address map and cia register constants */
package glue_pkg;

	// ----------------------------------------
	// data and address types
	typedef logic [15:0] word_t;      // cpu data word
	typedef logic [22:0] cpu_addr_t;  // word address, byte bits 23..1
	typedef logic [1:0]  byte_sel_t;  // bit 1 upper byte
	typedef logic [63:0] rtc_t;
	typedef logic [7:0]  cia_reg_t;

	typedef enum logic [2:0] {
		REGION_NONE,
		REGION_CHIP,
		REGION_KICK,
		REGION_CIAA,
		REGION_RTC
	} region_t;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_ACCESS,
		BUS_ACK
	} bus_state_t;

	// ----------------------------------------
	// memory sizes, both alias over their region
	localparam int CHIP_WORDS = 256;
	localparam int KICK_WORDS = 16;

	// byte address bounds
	localparam logic [23:0] CHIP_LO = 24'h000000;
	localparam logic [23:0] CHIP_HI = 24'h1FFFFF;
	localparam logic [23:0] CIAA_LO = 24'hBFE000;
	localparam logic [23:0] CIAA_HI = 24'hBFEFFF;
	localparam logic [23:0] RTC_LO  = 24'hDC0000;
	localparam logic [23:0] RTC_HI  = 24'hDCFFFF;
	localparam logic [23:0] KICK_LO = 24'hF80000;
	localparam logic [23:0] KICK_HI = 24'hFFFFFF;

	// cia register select, byte address bits 11..8
	localparam logic [3:0] CIA_RS_PRA  = 4'd0;
	localparam logic [3:0] CIA_RS_DDRA = 4'd2;
	localparam int LED_BIT = 1;  // low means led on

	localparam int DIM_CNT_W    = 6;
	localparam int RESET_STAGES = 2;
	localparam string KICK_HEX  = "kick_rom.hex";

endpackage

/* design/kick_rom.sv */
/* kickstart rom
   small synchronous rom preloaded from hex, writes have no effect */
`timescale 1ns/1ps

module kick_rom (
	input  logic              clk,
	cpu_bus_if.target         bus,
	input  glue_pkg::region_t region,
	output glue_pkg::word_t   data
);
	import glue_pkg::*;

	localparam int AW = $clog2(KICK_WORDS);

	word_t         rom [KICK_WORDS];
	logic [AW-1:0] idx;

	initial $readmemh(KICK_HEX, rom);

	assign idx = bus.adr[AW-1:0];  // mirrors over the kick region

	always_ff @(posedge clk)
		data <= (bus.rd && region == REGION_KICK) ? rom[idx] : '0;

endmodule

/* design/memory_map.sv */
/* address decoder
   splits the cpu address into regions, kickstart overlay maps chip reads to rom */
`timescale 1ns/1ps

module memory_map (
	input  logic              clk,
	input  logic              cpu_reset_n,
	cpu_bus_if.target         bus,
	input  logic              we,
	output glue_pkg::region_t region
);
	import glue_pkg::*;

	logic [23:0] byte_adr;  // full byte address, a0 always zero
	logic        ovl;       // kickstart overlay

	function automatic logic in_range(logic [23:0] a, logic [23:0] lo, logic [23:0] hi);
		return (a >= lo) && (a <= hi);
	endfunction

	assign byte_adr = {bus.adr, 1'b0};

	// combinational decode, valid while stb is up
	always_comb begin
		if (in_range(byte_adr, CHIP_LO, CHIP_HI))
			region = (ovl && !we) ? REGION_KICK : REGION_CHIP;  // writes still hit ram
		else if (in_range(byte_adr, KICK_LO, KICK_HI))
			region = REGION_KICK;
		else if (in_range(byte_adr, CIAA_LO, CIAA_HI))
			region = REGION_CIAA;
		else if (in_range(byte_adr, RTC_LO, RTC_HI))
			region = REGION_RTC;
		else
			region = REGION_NONE;
	end

	// overlay set during cpu reset, dropped by the first cia-a write
	always_ff @(posedge clk) begin
		if (!cpu_reset_n)
			ovl <= 1'b1;
		else if ((bus.hwr || bus.lwr) && region == REGION_CIAA)
			ovl <= 1'b0;
	end

endmodule

/* design/minimig_glue.sv */
/* cpu glue top level
   wishbone slave in front of chip ram, kickstart rom, cia-a port a and rtc */
`timescale 1ns/1ps

module minimig_glue (
	input  logic                clk,
	input  logic                reset,
	// wishbone classic slave
	input  logic                cyc,
	input  logic                stb,
	input  logic                we,
	input  glue_pkg::byte_sel_t sel,
	input  glue_pkg::cpu_addr_t adr,
	input  glue_pkg::word_t     dat_w,
	output glue_pkg::word_t     dat_r,
	output logic                ack,
	// system pins
	input  glue_pkg::rtc_t      rtc,
	input  glue_pkg::cia_reg_t  port_a_in,
	output logic                pwr_led,
	output logic                cpu_reset_n
);
	import glue_pkg::*;

	cpu_bus_if bus ();

	region_t region;       // decoded target
	word_t   ram_data;
	word_t   rom_data;
	word_t   periph_data;
	logic    led_n;        // cia-a led bit, active low

	bus_controller ctrl (
		.clk         (clk),
		.reset       (reset),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.sel         (sel),
		.adr         (adr),
		.dat_w       (dat_w),
		.dat_r       (dat_r),
		.ack         (ack),
		.bus         (bus.controller),
		.ram_data    (ram_data),
		.rom_data    (rom_data),
		.periph_data (periph_data)
	);

	memory_map map (
		.clk         (clk),
		.cpu_reset_n (cpu_reset_n),
		.bus         (bus.target),
		.we          (we),
		.region      (region)
	);

	chip_ram ram (.clk(clk), .bus(bus.target), .region(region), .data(ram_data));

	kick_rom rom (.clk(clk), .bus(bus.target), .region(region), .data(rom_data));

	peripheral_regs periph (
		.clk       (clk),
		.reset     (reset),
		.bus       (bus.target),
		.region    (region),
		.rtc       (rtc),
		.port_a_in (port_a_in),
		.led_n     (led_n),
		.data      (periph_data)
	);

	system_control sysctl (
		.clk         (clk),
		.reset       (reset),
		.led_n       (led_n),
		.cpu_reset_n (cpu_reset_n),
		.pwr_led     (pwr_led)
	);

endmodule

/* design/peripheral_regs.sv */
/* cia-a port a and rtc window
   pra/ddra with pin mixing on reads, plus read only rtc nibbles */
`timescale 1ns/1ps

module peripheral_regs (
	input  logic               clk,
	input  logic               reset,
	cpu_bus_if.target          bus,
	input  glue_pkg::region_t  region,
	input  glue_pkg::rtc_t     rtc,
	input  glue_pkg::cia_reg_t port_a_in,
	output logic               led_n,
	output glue_pkg::word_t    data
);
	import glue_pkg::*;

	cia_reg_t   pra;      // port a output latch
	cia_reg_t   ddra;     // 1 = output
	cia_reg_t   pra_rd;   // value seen on a pra read
	logic [3:0] rs;       // register select

	assign rs     = bus.adr[10:7];  // byte bits 11..8
	assign pra_rd = (pra & ddra) | (port_a_in & ~ddra);
	assign led_n  = ddra[LED_BIT] ? pra[LED_BIT] : 1'b1;  // input bit floats high

	// cia sits on the low byte only
	always_ff @(posedge clk) begin
		if (reset) begin
			pra  <= '0;
			ddra <= '0;
		end else if (bus.lwr && region == REGION_CIAA) begin
			if (rs == CIA_RS_PRA)
				pra <= bus.dat_w[7:0];
			if (rs == CIA_RS_DDRA)
				ddra <= bus.dat_w[7:0];
		end
	end

	// read path, one cycle behind rd
	always_ff @(posedge clk) begin
		data <= '0;
		if (bus.rd && region == REGION_CIAA) begin
			case (rs)
				CIA_RS_PRA:  data <= {8'h00, pra_rd};
				CIA_RS_DDRA: data <= {8'h00, ddra};
				default:     data <= '0;  // unimplemented selects
			endcase
		end else if (bus.rd && region == REGION_RTC) begin
			data <= {12'h000, rtc[{bus.adr[4:1], 2'b00} +: 4]};  // nibble by byte bits 5..2
		end
	end

endmodule

/* design/system_control.sv */
/* system control
   delayed cpu reset release and pwm dimmed power led */
`timescale 1ns/1ps

module system_control (
	input  logic clk,
	input  logic reset,
	input  logic led_n,
	output logic cpu_reset_n,
	output logic pwr_led
);
	import glue_pkg::*;

	logic [RESET_STAGES-1:0] rst_sync;  // shifts in ones after reset
	logic [DIM_CNT_W-1:0]    dim_cnt;
	logic                    dim;

	// ----------------------------------------
	// cpu reset delay
	always_ff @(posedge clk) begin
		if (reset)
			rst_sync <= '0;
		else
			rst_sync <= {rst_sync[RESET_STAGES-2:0], 1'b1};
	end

	assign cpu_reset_n = rst_sync[RESET_STAGES-1];  // high after the last stage fills

	// ----------------------------------------
	// power led dimmer
	always_ff @(posedge clk) begin
		if (reset) begin
			dim_cnt <= '0;
			dim     <= 1'b0;
		end else begin
			dim_cnt <= dim_cnt + 1'b1;  // free running
			dim     <= |dim_cnt[DIM_CNT_W-1 -: 4];
		end
	end

	// full on when the led bit is low
	// otherwise lit only while the upper counter bits are all zero
	assign pwr_led = ~(led_n & dim);

endmodule

/* kick_rom.hex */
// kickstart rom, one 16 bit hex word per line, word offsets 0 to 15
1114
4ef9
00fc
00d2
0001
ffff
a5a5
5a5a
1234
abcd
0f0f
f0f0
8001
7ffe
c0de
beef

/* run_sim.sh */
#!/bin/sh
# build and run the glue testbench with verilator
# run from the project root so the rom hex file is found
cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_minimig_glue -Mdir "$obj" -o tb_sim -f tb.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$obj/tb_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$log"; then
	exit 1
fi
exit 0

/* tb.f */
design/glue_pkg.sv
design/cpu_bus_if.sv
design/bus_controller.sv
design/memory_map.sv
design/chip_ram.sv
design/kick_rom.sv
design/peripheral_regs.sv
design/system_control.sv
design/minimig_glue.sv
verification/glue_properties.sv
verification/tb_minimig_glue.sv

/* verification/glue_properties.sv */
/* bus and reset checks
   concurrent assertions bound onto the glue top level */
`timescale 1ns/1ps

module glue_properties (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic cpu_reset_n
);

	logic busy;    // request taken at the last edge
	logic accept;  // request sampled while the slave is idle

	assign accept = !reset && cyc && stb && !ack && !busy;

	always_ff @(posedge clk) begin
		if (reset)
			busy <= 1'b0;
		else
			busy <= accept;
	end

	// ----------------------------------------
	ack_single: assert property (@(posedge clk) disable iff (reset) $past(ack) |-> !ack)
		else $error("ack high on two cycles in a row");

	ack_latency: assert property (@(posedge clk) disable iff (reset)
		$past(accept, 2) |-> ack && !$past(ack))
		else $error("ack did not rise two cycles after the request");

	// held through the edge after reset
	reset_hold: assert property (@(posedge clk) $past(reset) |-> !cpu_reset_n)
		else $error("cpu reset released too early");

endmodule

bind minimig_glue glue_properties props (
	.clk         (clk),
	.reset       (reset),
	.cyc         (cyc),
	.stb         (stb),
	.ack         (ack),
	.cpu_reset_n (cpu_reset_n)
);

/* verification/tb_minimig_glue.sv */
/* minimig glue testbench
   random wishbone traffic against a reference model of the cpu glue */
`timescale 1ns/1ps

module tb_minimig_glue;
	import glue_pkg::*;

	localparam int CLK_HALF      = 50;   // 100 ns period
	localparam int ACK_LIMIT     = 20;   // cycles before an access counts as lost
	localparam int ACCESSES      = 240;  // all bus accesses of the run, rounded up
	localparam int MARGIN_CYCLES = 400;  // led windows, resets, slack

	// word addresses, byte address shifted right by one
	localparam cpu_addr_t CIA_WORD  = 23'h5FF000;  // byte 0xBFE000
	localparam cpu_addr_t RTC_WORD  = 23'h6E0000;  // byte 0xDC0000
	localparam cpu_addr_t KICK_WORD = 23'h7C0000;  // byte 0xF80000
	localparam cpu_addr_t NONE_WORD = 23'h200000;  // byte 0x400000, nothing there

	logic      clk = 1'b0;
	logic      reset;
	logic      cyc;
	logic      stb;
	logic      we;
	byte_sel_t sel;
	cpu_addr_t adr;
	word_t     dat_w;
	word_t     dat_r;
	logic      ack;
	rtc_t      rtc;
	cia_reg_t  port_a_in;
	logic      pwr_led;
	logic      cpu_reset_n;

	integer seed = 32'hfbd7;
	int     errors = 0;
	int     test_start = 0;
	int     tests_run = 0;
	int     tests_failed = 0;

	// ----------------------------------------
	// reference model
	word_t     rom_model [KICK_WORDS];
	word_t     ram_model [CHIP_WORDS];
	word_t     ram_mask  [CHIP_WORDS];  // byte lanes written so far
	logic      ovl_model;
	cia_reg_t  pra_model;
	cia_reg_t  ddra_model;
	cpu_addr_t written [$];             // chip addresses hit by writes

	minimig_glue i_dut (.*);

	always #CLK_HALF clk = ~clk;

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
			errors++;
		end
	endtask

	// ----------------------------------------
	// wishbone classic master, one access per call
	task automatic bus_access(input logic wr, input cpu_addr_t a, input byte_sel_t s,
			input word_t d, output word_t q);
		int waited;
		@(negedge clk);
		check(ack, 1'b0, "ack low between accesses");  // one ack per access
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = wr;
		sel   = s;
		adr   = a;
		dat_w = d;
		q      = '0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!ack && waited < ACK_LIMIT);
		if (ack) begin
			check(waited, 2, "ack latency in cycles");
			q = dat_r;
		end else begin
			$display("Error at %0t ns: no ack for address %h within %0d cycles",
				$time, a, ACK_LIMIT);
			errors++;
		end
		cyc = 1'b0;  // drop on the ack cycle
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic bus_write(input cpu_addr_t a, input byte_sel_t s, input word_t d);
		word_t unused;
		bus_access(1'b1, a, s, d, unused);
	endtask

	task automatic bus_read(input cpu_addr_t a, output word_t q);
		bus_access(1'b0, a, 2'b11, '0, q);
	endtask

	// chip write, ram takes it even under overlay
	task automatic chip_write(input cpu_addr_t a, input byte_sel_t s, input word_t d);
		int i;
		i = int'(a % CHIP_WORDS);
		bus_write(a, s, d);
		if (s[1]) begin
			ram_model[i][15:8] = d[15:8];
			ram_mask[i][15:8]  = 8'hff;
		end
		if (s[0]) begin
			ram_model[i][7:0] = d[7:0];
			ram_mask[i][7:0]  = 8'hff;
		end
		written.push_back(a);
	endtask

	// chip read, rom word under overlay, else ram
	task automatic chip_verify(input cpu_addr_t a);
		int    i;
		word_t q;
		i = int'(a % CHIP_WORDS);
		bus_read(a, q);
		if (ovl_model)
			check(q, rom_model[a % KICK_WORDS], "overlay read of chip region");
		else
			check(q & ram_mask[i], ram_model[i] & ram_mask[i], "chip ram read");  // written lanes only
	endtask

	task automatic cia_write(input logic [3:0] rs, input cia_reg_t v);
		byte_sel_t s;
		s = {1'($random(seed)), 1'b1};  // low lane always, upper lane random
		bus_write(CIA_WORD | (cpu_addr_t'(rs) << 7), s, {8'($random(seed)), v});
		ovl_model = 1'b0;
		if (rs == CIA_RS_PRA)
			pra_model = v;
		if (rs == CIA_RS_DDRA)
			ddra_model = v;
	endtask

	task automatic cia_read(input logic [3:0] rs, output word_t q);
		bus_read(CIA_WORD | (cpu_addr_t'(rs) << 7), q);  // select in byte bits 11..8
	endtask

	// 64 samples of the power led against the dimming rule
	task automatic count_led();
		int on;
		int exp_on;
		on     = 0;
		exp_on = (ddra_model[LED_BIT] && !pra_model[LED_BIT]) ? 64 : 4;
		repeat (64) begin
			@(negedge clk);
			if (pwr_led)
				on++;
		end
		check(on, exp_on, "power led on count over 64 cycles");
	endtask

	// reset for 4 cycles, then the cpu reset release timing
	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		check(cpu_reset_n, 1'b0, "cpu reset at first edge after release");
		@(negedge clk);
		check(cpu_reset_n, 1'b0, "cpu reset at second edge after release");
		@(negedge clk);
		check(cpu_reset_n, 1'b1, "cpu reset at third edge after release");
		ovl_model  = 1'b1;
		pra_model  = '0;
		ddra_model = '0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_start);
		end
		test_start = errors;
	endtask

	// ----------------------------------------
	// watchdog
	initial begin
		#(CLK_HALF * 2 * (ACCESSES * 10 + MARGIN_CYCLES));
		$display("Error: watchdog expired, the run did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		cpu_addr_t a;
		word_t     q;
		word_t     expv;
		int        nib;
		reset     = 1'b1;
		cyc       = 1'b0;
		stb       = 1'b0;
		we        = 1'b0;
		sel       = '0;
		adr       = '0;
		dat_w     = '0;
		rtc       = '0;
		port_a_in = '0;
		$readmemh(KICK_HEX, rom_model);
		foreach (ram_mask[i])
			ram_mask[i] = '0;
		apply_reset();

		// overlay boot, chip reads come from rom
		repeat (16) begin
			a = cpu_addr_t'($random(seed)) & 23'h0FFFFF;
			chip_verify(a);
			a = cpu_addr_t'($random(seed)) & 23'h0FFFFF;
			chip_write(a, byte_sel_t'($random(seed)), word_t'($random(seed)));
		end
		end_test("overlay boot");

		// cia write drops overlay, ram visible incl. boot writes
		cia_write(CIA_RS_PRA, 8'h00);
		repeat (24) begin
			a = cpu_addr_t'($random(seed)) & 23'h0FFFFF;
			chip_write(a, byte_sel_t'($random(seed)), word_t'($random(seed)));
		end
		foreach (written[k])
			chip_verify(written[k]);
		end_test("overlay clear and chip ram");

		// rom ignores writes, unmapped reads zero
		repeat (16) begin
			a = KICK_WORD | (cpu_addr_t'($random(seed)) & 23'h03FFFF);
			bus_write(a, 2'b11, word_t'($random(seed)));
			bus_read(a, q);
			check(q, rom_model[a % KICK_WORDS], "kick rom read");
			bus_read(NONE_WORD | (cpu_addr_t'($random(seed)) & 23'h0FFFFF), q);
			check(q, 16'h0000, "unmapped read");
		end
		for (int k = 0; k < 8; k++)
			chip_verify(written[k]);  // rom writes left ram alone
		end_test("rom and unmapped");

		// rtc window, nibble by byte address bits 5..2
		repeat (2) begin
			rtc = {$random(seed), $random(seed)};
			for (nib = 0; nib < 16; nib++) begin
				bus_read(RTC_WORD + cpu_addr_t'(nib * 2), q);
				check(q, (rtc >> (nib * 4)) & 64'hF, "rtc nibble");
			end
		end
		end_test("rtc window");

		// port a mixing, pins where the direction is in
		repeat (8) begin
			port_a_in = cia_reg_t'($random(seed));
			cia_write(CIA_RS_DDRA, cia_reg_t'($random(seed)));
			cia_write(CIA_RS_PRA, cia_reg_t'($random(seed)));
			expv = '0;
			for (int b = 0; b < 8; b++)
				expv[b] = ddra_model[b] ? pra_model[b] : port_a_in[b];  // out bit or pin
			cia_read(CIA_RS_PRA, q);
			check(q, expv, "pra read");
			cia_read(CIA_RS_DDRA, q);
			check(q, {8'h00, ddra_model}, "ddra read");
			cia_read(4'd1, q);
			check(q, 16'h0000, "unused cia select");
		end
		cia_write(CIA_RS_DDRA, 8'h00);  // led bit input, dimmed
		count_led();
		cia_write(CIA_RS_DDRA, 8'h02);
		cia_write(CIA_RS_PRA, 8'h02);   // driven high, still dimmed
		count_led();
		cia_write(CIA_RS_PRA, 8'h00);   // driven low, full on
		count_led();
		end_test("cia-a port a");

		// second reset brings overlay and port a defaults back
		apply_reset();
		port_a_in = cia_reg_t'($random(seed));
		chip_verify(written[0]);
		cia_read(CIA_RS_DDRA, q);
		check(q, 16'h0000, "ddra after reset");
		cia_read(CIA_RS_PRA, q);
		check(q, {8'h00, port_a_in}, "pra after reset");
		count_led();
		end_test("reset and handshake");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
